// ==== source/gb_dma_pkg.sv ====
package gb_dma_pkg;

	localparam logic [15:0] dma_reg_addr = 16'hff46; // source page register
	localparam int          oam_len      = 160;
	localparam logic [7:0]  oam_last     = 8'(oam_len - 1);
	localparam logic [2:0]  vram_region  = 3'b100; // 0x8000-0x9fff

	// source address seen as page/offset
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} page_view_t;

	// source address seen as region/local
	typedef struct packed {
		logic [2:0]  region;
		logic [12:0] local_addr;
	} region_view_t;

	typedef union packed {
		page_view_t   pg;
		region_view_t rg;
	} dma_addr_u;

	typedef struct packed {
		logic      valid;
		dma_addr_u addr;
		logic [7:0] idx; // oam index
	} fetch_req_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic [7:0] idx;
	} fetch_rsp_t;

endpackage

// ==== source/dma_reg_apb.sv ====
`timescale 1ns/10ps

module dma_reg_apb(
		input  logic        clk1,
		input  logic        reset,

		input  logic        psel,
		input  logic        penable,
		input  logic        pwrite,
		input  logic [15:0] paddr,
		input  logic [7:0]  pwdata,
		output logic [7:0]  prdata,
		output logic        pready,
		output logic        pslverr,

		output logic        start,
		output logic [7:0]  page
	);

	logic access;
	logic hit;
	logic reg_wr;
	logic reg_rd;

	assign access = psel && penable; // access phase
	assign hit    = (paddr == gb_dma_pkg::dma_reg_addr);
	assign reg_wr = access && pwrite && hit;
	assign reg_rd = access && !pwrite && hit;

	always_ff @(posedge clk1) begin
		if (reset) begin
			page <= 8'h00;
		end else if (reg_wr) begin
			page <= pwdata; // like the ff46 latch
		end
	end

	// write of the register kicks (or restarts) the copy
	assign start = reg_wr;

	assign prdata  = reg_rd ? page : 8'h00;
	assign pready  = 1'b1; // no wait states
	assign pslverr = access && !hit;

endmodule

// ==== source/dma_sequencer.sv ====
`timescale 1ns/10ps

module dma_sequencer(
		input  logic                   clk1,
		input  logic                   reset,
		input  logic                   start,
		input  logic [7:0]             page,
		input  logic                   done,

		output gb_dma_pkg::fetch_req_t vram_req,
		output gb_dma_pkg::fetch_req_t ext_req,
		output logic                   dma_busy
	);

	logic                  busy;
	logic                  restart_pend; // start seen, first request not yet out
	logic                  inflight;     // a byte is between request and done
	logic                  more;         // indices left to request
	logic [7:0]            idx;          // next index to request
	logic                  issue;
	logic                  to_vram;
	gb_dma_pkg::dma_addr_u src;

	always_comb begin
		src           = '0;
		src.pg.page   = page;
		src.pg.offset = idx;
	end

	assign to_vram = (src.rg.region == gb_dma_pkg::vram_region);

	// a start in the same cycle wins, the request goes out two cycles later
	assign issue = busy && more && !start && (done || (restart_pend && !inflight));

	always_ff @(posedge clk1) begin
		if (reset) begin
			busy         <= 1'b0;
			restart_pend <= 1'b0;
			inflight     <= 1'b0;
			more         <= 1'b0;
			idx          <= 8'h00;
			vram_req     <= '0;
			ext_req      <= '0;
		end else begin
			vram_req.valid <= 1'b0;
			ext_req.valid  <= 1'b0;

			if (start) begin
				busy         <= 1'b1;
				restart_pend <= 1'b1;
				more         <= 1'b1;
				idx          <= 8'h00; // copy starts over at index 0
			end else if (issue) begin
				restart_pend   <= 1'b0;
				idx            <= idx + 8'd1;
				more           <= (idx != gb_dma_pkg::oam_last);
				vram_req.valid <= to_vram;
				ext_req.valid  <= !to_vram;
				vram_req.addr  <= src;
				vram_req.idx   <= idx;
				ext_req.addr   <= src;
				ext_req.idx    <= idx;
			end else if (done && !more) begin
				busy <= 1'b0; // last byte written
			end

			if (issue) begin
				inflight <= 1'b1;
			end else if (done) begin
				inflight <= 1'b0;
			end
		end
	end

	assign dma_busy = busy;

endmodule

// ==== source/vram_fetch.sv ====
`timescale 1ns/10ps

module vram_fetch(
		input  logic                   clk1,
		input  logic                   reset,
		input  gb_dma_pkg::fetch_req_t req,

		output logic                   vram_rd,
		output logic [12:0]            vram_addr,
		input  logic [7:0]             vram_rdata,

		output gb_dma_pkg::fetch_rsp_t rsp
	);

	logic        rd_q;
	logic        rvalid_q; // memory data out this cycle
	logic [12:0] addr_q;
	logic [7:0]  idx_q;

	always_ff @(posedge clk1) begin
		if (reset) begin
			rd_q     <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			rd_q     <= req.valid;
			rvalid_q <= rd_q;
		end
	end

	always_ff @(posedge clk1) begin
		if (req.valid) begin
			addr_q <= req.addr.rg.local_addr; // 13 bit vram offset
			idx_q  <= req.idx;
		end
	end

	assign vram_rd   = rd_q;
	assign vram_addr = addr_q;

	always_comb begin
		rsp.valid = rvalid_q;
		rsp.data  = vram_rdata; // sync ram, data a cycle after rd
		rsp.idx   = idx_q;
	end

endmodule

// ==== source/ext_fetch.sv ====
`timescale 1ns/10ps

module ext_fetch(
		input  logic                   clk1,
		input  logic                   reset,
		input  gb_dma_pkg::fetch_req_t req,

		output logic                   ext_rd,
		output logic [15:0]            ext_addr,
		input  logic [7:0]             ext_rdata,
		input  logic                   ext_ready,

		output gb_dma_pkg::fetch_rsp_t rsp
	);

	logic        waiting; // 0 idle, 1 bus cycle open
	logic        rsp_valid;
	logic [15:0] addr_q;
	logic [7:0]  idx_q;
	logic [7:0]  data_q;

	always_ff @(posedge clk1) begin
		if (reset) begin
			waiting   <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			if (!waiting) begin
				if (req.valid) begin
					waiting <= 1'b1;
				end
			end else if (ext_ready) begin
				waiting   <= 1'b0;
				rsp_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk1) begin
		if (req.valid && !waiting) begin
			addr_q <= req.addr; // full 16 bit address
			idx_q  <= req.idx;
		end
		if (waiting && ext_ready) begin
			data_q <= ext_rdata;
		end
	end

	// address held for the whole stall
	assign ext_rd   = waiting;
	assign ext_addr = addr_q;

	always_comb begin
		rsp.valid = rsp_valid;
		rsp.data  = data_q;
		rsp.idx   = idx_q;
	end

endmodule

// ==== source/oam_writer.sv ====
`timescale 1ns/10ps

module oam_writer(
		input  logic                   clk1,
		input  logic                   reset,
		input  gb_dma_pkg::fetch_rsp_t vram_rsp,
		input  gb_dma_pkg::fetch_rsp_t ext_rsp,

		output logic                   oam_we,
		output logic [7:0]             oam_addr,
		output logic [7:0]             oam_wdata,
		output logic                   done
	);

	logic we_q;

	always_ff @(posedge clk1) begin
		if (reset) begin
			we_q <= 1'b0;
		end else begin
			we_q <= vram_rsp.valid || ext_rsp.valid; // one byte in flight
		end
	end

	always_ff @(posedge clk1) begin
		if (vram_rsp.valid) begin
			oam_addr  <= vram_rsp.idx;
			oam_wdata <= vram_rsp.data;
		end else if (ext_rsp.valid) begin
			oam_addr  <= ext_rsp.idx;
			oam_wdata <= ext_rsp.data;
		end
	end

	assign oam_we = we_q;

	// frees the sequencer for the next index
	assign done = we_q;

endmodule

// ==== source/gb_dma_top.sv ====
`timescale 1ns/10ps

module gb_dma_top(
		input  logic        clk1,
		input  logic        reset,

		input  logic        psel,
		input  logic        penable,
		input  logic        pwrite,
		input  logic [15:0] paddr,
		input  logic [7:0]  pwdata,
		output logic [7:0]  prdata,
		output logic        pready,
		output logic        pslverr,

		output logic        vram_rd,
		output logic [12:0] vram_addr,
		input  logic [7:0]  vram_rdata,

		output logic        ext_rd,
		output logic [15:0] ext_addr,
		input  logic [7:0]  ext_rdata,
		input  logic        ext_ready,

		output logic        oam_we,
		output logic [7:0]  oam_addr,
		output logic [7:0]  oam_wdata,

		output logic        dma_busy
	);

	logic                   start;
	logic [7:0]             page;
	logic                   done;
	gb_dma_pkg::fetch_req_t vram_req;
	gb_dma_pkg::fetch_req_t ext_req;
	gb_dma_pkg::fetch_rsp_t vram_rsp;
	gb_dma_pkg::fetch_rsp_t ext_rsp;

	dma_reg_apb u_reg(
		.clk1(clk1), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .page(page)
	);

	dma_sequencer u_seq(
		.clk1(clk1), .reset(reset),
		.start(start), .page(page), .done(done),
		.vram_req(vram_req), .ext_req(ext_req),
		.dma_busy(dma_busy)
	);

	vram_fetch u_vram(
		.clk1(clk1), .reset(reset),
		.req(vram_req),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .vram_rdata(vram_rdata),
		.rsp(vram_rsp)
	);

	ext_fetch u_ext(
		.clk1(clk1), .reset(reset),
		.req(ext_req),
		.ext_rd(ext_rd), .ext_addr(ext_addr),
		.ext_rdata(ext_rdata), .ext_ready(ext_ready),
		.rsp(ext_rsp)
	);

	oam_writer u_oam(
		.clk1(clk1), .reset(reset),
		.vram_rsp(vram_rsp), .ext_rsp(ext_rsp),
		.oam_we(oam_we), .oam_addr(oam_addr), .oam_wdata(oam_wdata),
		.done(done)
	);

endmodule

// ==== bench/gb_dma_chk.sv ====
`timescale 1ns/10ps

module gb_dma_chk(
		input logic        clk1,
		input logic        reset,
		input logic        oam_we,
		input logic        vram_rd,
		input logic        ext_rd,
		input logic [15:0] ext_addr,
		input logic        ext_ready,
		input logic        dma_busy
	);

	oam_we_single: assert property (@(posedge clk1) disable iff (reset) oam_we |=> !oam_we)
		else $error("oam_we high for two cycles in a row");

	one_source: assert property (@(posedge clk1) disable iff (reset) !(vram_rd && ext_rd))
		else $error("vram_rd and ext_rd high together");

	// stalled bus cycle keeps its address
	ext_hold: assert property (@(posedge clk1) disable iff (reset)
			(ext_rd && !ext_ready) |=> (ext_rd && ext_addr == $past(ext_addr)))
		else $error("ext_addr or ext_rd changed during a stall");

	busy_in_reset: assert property (@(posedge clk1) reset |=> !dma_busy)
		else $error("dma_busy high during reset");

endmodule

bind gb_dma_top gb_dma_chk chk(
	.clk1(clk1), .reset(reset), .oam_we(oam_we), .vram_rd(vram_rd), .ext_rd(ext_rd),
	.ext_addr(ext_addr), .ext_ready(ext_ready), .dma_busy(dma_busy)
);

// ==== bench/gb_dma_tb.sv ====
`timescale 1ns/10ps

module gb_dma_tb;

	logic        clk1;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [15:0] paddr;
	logic [7:0]  pwdata;
	logic [7:0]  prdata;
	logic        pready;
	logic        pslverr;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_rdata = 8'h00;
	logic        ext_rd;
	logic [15:0] ext_addr;
	logic [7:0]  ext_rdata = 8'h00;
	logic        ext_ready = 1'b0;
	logic        oam_we;
	logic [7:0]  oam_addr;
	logic [7:0]  oam_wdata;
	logic        dma_busy;

	logic [31:0] lfsr_state = 32'h64af;
	logic [7:0]  shadow [0:255]; // last byte written per oam index
	logic [7:0]  last_idx;
	logic [7:0]  cur_page;
	logic        live;      // check order and data of each write
	logic        vram_mode; // ext bus must stay idle
	logic        timed_out;
	int          wr_count;
	int          seq_idx;
	int          base;
	int          chk_errors;
	int          errors;
	logic [7:0]  rd_data;
	logic        rd_err;
	logic [15:0] exp_addr;

	gb_dma_top DUT(.*);

	initial begin
		clk1 = 1'b0;
		forever #4 clk1 = ~clk1;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// expected byte at a source address
	function automatic logic [7:0] ref_byte(input logic [15:0] a);
		return ({a[11:8], a[15:12]} ^ a[7:0]) + 8'h5b;
	endfunction

	// vram and external bus models
	always @(negedge clk1) begin
		if (vram_rd)
			vram_rdata = ref_byte({gb_dma_pkg::vram_region, vram_addr});
		if (ext_rd)
			ext_rdata = ref_byte(ext_addr);
		lfsr_state = lfsr_step(lfsr_state);
		ext_ready = lfsr_state[0];
	end

	initial begin
		wr_count = 0;
		chk_errors = 0;
	end

	always @(negedge clk1) begin
		if (!reset) begin
			seq_idx = wr_count - base;
			if (oam_we) begin
				shadow[oam_addr] = oam_wdata;
				last_idx = oam_addr;
				if (live && oam_addr != seq_idx[7:0]) begin
					$display("mismatch at %0t: oam index %0d expected %0d", $time,
						oam_addr, seq_idx[7:0]);
					chk_errors++;
				end
				if (live && oam_wdata != ref_byte({cur_page, oam_addr})) begin
					$display("mismatch at %0t: oam[%0d] got %02h expected %02h", $time,
						oam_addr, oam_wdata, ref_byte({cur_page, oam_addr}));
					chk_errors++;
				end
				if (!dma_busy) begin
					$display("oam write at %0t while dma_busy was already low", $time);
					chk_errors++;
				end
				wr_count++;
			end
			if (vram_mode && ext_rd) begin
				$display("external bus read at %0t during a vram page copy", $time);
				chk_errors++;
			end
			exp_addr = {cur_page, seq_idx[7:0]};
			if (vram_mode && vram_rd && vram_addr != exp_addr[12:0]) begin
				$display("mismatch at %0t: vram_addr %04h expected %04h", $time,
					vram_addr, exp_addr[12:0]);
				chk_errors++;
			end
		end
	end

	// called on a falling edge, returns on a falling edge
	task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk1);
		penable = 1'b1; // access phase
		@(posedge clk1);
		rdata = prdata;
		err = pslverr;
		if (!pready) begin
			$display("mismatch at %0t: pready 0 expected 1", $time);
			errors++;
		end
		@(negedge clk1);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (dma_busy && n < limit && !timed_out) begin
			@(negedge clk1);
			n++;
		end
		if (dma_busy && !timed_out) begin
			$display("timeout: transfer still busy after %0d cycles", limit);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic wait_writes(input int count, input int limit);
		int n;
		n = 0;
		while (wr_count < count && n < limit && !timed_out) begin
			@(negedge clk1);
			n++;
		end
		if (wr_count < count && !timed_out) begin
			$display("timeout: only %0d of %0d oam writes seen", wr_count, count);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic run_copy(input logic [7:0] pg, input logic from_vram);
		cur_page = pg;
		vram_mode = from_vram;
		base = wr_count;
		live = 1'b1;
		apb_xfer(1'b1, gb_dma_pkg::dma_reg_addr, pg, rd_data, rd_err);
		wait_idle(5000);
		repeat (4) @(negedge clk1);
		if (wr_count - base != gb_dma_pkg::oam_len) begin
			$display("page %02h copy made %0d oam writes instead of 160", pg, wr_count - base);
			errors++;
		end
		live = 1'b0;
		vram_mode = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 16'h0000;
		pwdata = 8'h00;
		live = 1'b0;
		vram_mode = 1'b0;
		cur_page = 8'h00;
		base = 0;
		errors = 0;
		timed_out = 1'b0;
		repeat (10) @(negedge clk1);
		reset = 1'b0;
		@(negedge clk1);

		if (dma_busy || oam_we || vram_rd || ext_rd) begin
			$display("outputs not idle after reset");
			errors++;
		end
		apb_xfer(1'b0, gb_dma_pkg::dma_reg_addr, 8'h00, rd_data, rd_err);
		if (rd_data != 8'h00) begin
			$display("mismatch at %0t: page after reset %02h expected 00", $time, rd_data);
			errors++;
		end

		run_copy(8'hc1, 1'b0); // external page, random stalls
		run_copy(8'h85, 1'b1); // vram page

		apb_xfer(1'b0, gb_dma_pkg::dma_reg_addr, 8'h00, rd_data, rd_err);
		if (rd_data != 8'h85 || rd_err) begin
			$display("mismatch at %0t: page read %02h err %0b expected 85 err 0", $time,
				rd_data, rd_err);
			errors++;
		end
		apb_xfer(1'b1, 16'hff40, 8'h12, rd_data, rd_err);
		if (!rd_err) begin
			$display("write to ff40 gave no pslverr");
			errors++;
		end
		repeat (3) @(negedge clk1);
		if (dma_busy) begin
			$display("write to ff40 started a transfer");
			errors++;
		end
		apb_xfer(1'b0, 16'hff40, 8'h00, rd_data, rd_err);
		if (rd_data != 8'h00 || !rd_err) begin
			$display("mismatch at %0t: ff40 read %02h err %0b expected 00 err 1", $time,
				rd_data, rd_err);
			errors++;
		end

		// restart in mid copy from an ext page to a vram page
		base = wr_count;
		apb_xfer(1'b1, gb_dma_pkg::dma_reg_addr, 8'hc1, rd_data, rd_err);
		wait_writes(base + 40, 3000);
		apb_xfer(1'b1, gb_dma_pkg::dma_reg_addr, 8'h9a, rd_data, rd_err);
		wait_idle(5000);
		for (int i = 0; i < gb_dma_pkg::oam_len; i++) begin
			if (shadow[i[7:0]] != ref_byte({8'h9a, i[7:0]})) begin
				$display("mismatch at %0t: oam[%0d] holds %02h expected %02h", $time, i,
					shadow[i[7:0]], ref_byte({8'h9a, i[7:0]}));
				errors++;
			end
		end
		if (last_idx != gb_dma_pkg::oam_last) begin
			$display("mismatch at %0t: last write index %0d expected 159", $time, last_idx);
			errors++;
		end

		repeat (5) @(negedge clk1);
		$display("%0d errors (%0d sequence, %0d write checks), %0d oam writes",
			errors + chk_errors, errors, chk_errors, wr_count);
		if (errors + chk_errors == 0 && !timed_out)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
source/gb_dma_pkg.sv
source/dma_reg_apb.sv
source/dma_sequencer.sv
source/vram_fetch.sv
source/ext_fetch.sv
source/oam_writer.sv
source/gb_dma_top.sv
bench/gb_dma_chk.sv
bench/gb_dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the OAM DMA testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module gb_dma_tb -o gb_dma_sim &&
./obj_dir/gb_dma_sim | tee /dev/stderr | grep "TB PASSED" > /dev/null &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation did not pass"; exit 1; }
